//--- rtl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    localparam int WORD_W = 32;
    localparam int SREG_N = 32;
    localparam int MREG_N = 64;

    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [$clog2(SREG_N)-1:0] sreg_t;
    typedef logic [$clog2(MREG_N)-1:0] mreg_t;
    typedef logic [1:0]                tag_t;
    typedef logic [WORD_W-1:0]         imm_t;
    typedef logic [4:0]                fu_mask_t;
    typedef logic [3:0]                op_t;

    // busy mask bit positions
    localparam int FU_ALU_BIT    = 0;
    localparam int FU_LD_ST_BIT  = 1;
    localparam int FU_BRANCH_BIT = 2;
    localparam int FU_MLS_BIT    = 3;
    localparam int FU_GEMM_BIT   = 4;

    // producer tags, 0 means ready
    localparam tag_t TAG_S_ALU  = 2'd1;
    localparam tag_t TAG_S_JUMP = 2'd2;
    localparam tag_t TAG_S_LOAD = 2'd3;
    localparam tag_t TAG_M_GEMM = 2'd1;
    localparam tag_t TAG_M_LOAD = 2'd2;

    typedef enum logic [1:0] {
        FU_S_NONE   = 2'd0,
        FU_S_ALU    = 2'd1,
        FU_S_LD_ST  = 2'd2,
        FU_S_BRANCH = 2'd3
    } fu_s_t;

    typedef enum logic [1:0] {
        FU_M_NONE  = 2'd0,
        FU_M_LD_ST = 2'd1,
        FU_M_GEMM  = 2'd2
    } fu_m_t;

    typedef enum logic [6:0] {
        OP_NOP    = 7'b0000000,
        OP_ALU_R  = 7'b0110011,
        OP_ALU_I  = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111,
        OP_HALT   = 7'b1111111
    } opcode_t;

endpackage

`default_nettype wire

//--- rtl/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  dispatch_pkg::word_t instr,
    output dispatch_pkg::fu_s_t fu_s,
    output dispatch_pkg::fu_m_t fu_m,
    output logic                s_reg_write,
    output logic                m_reg_write,
    output logic                jal,
    output logic                jalr,
    output logic                halt,
    output logic                lui,
    output dispatch_pkg::imm_t  imm,
    output dispatch_pkg::op_t   op
);

    import dispatch_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    imm_t       imm_i;
    imm_t       imm_s;
    imm_t       imm_b;
    imm_t       imm_u;
    imm_t       imm_j;
    imm_t       imm_m;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    // matrix ld/st offset sits below the base register field
    assign imm_m = {{18{instr[20]}}, instr[20:7]};

    always_comb begin
        fu_s        = FU_S_NONE;
        fu_m        = FU_M_NONE;
        s_reg_write = 1'b0;
        m_reg_write = 1'b0;
        jal         = 1'b0;
        jalr        = 1'b0;
        halt        = 1'b0;
        lui         = 1'b0;
        imm         = '0;
        op          = {1'b0, funct3};
        case (opcode)
            OP_ALU_R: begin
                fu_s        = FU_S_ALU;
                s_reg_write = 1'b1;
                op          = {instr[30], funct3};
            end
            OP_ALU_I: begin
                fu_s        = FU_S_ALU;
                s_reg_write = 1'b1;
                imm         = imm_i;
                // only shifts use bit 30 as a function bit
                op          = {instr[30] & (funct3 == 3'b101), funct3};
            end
            OP_LUI: begin
                fu_s        = FU_S_ALU;
                s_reg_write = 1'b1;
                lui         = 1'b1;
                imm         = imm_u;
                op          = '0;
            end
            OP_LOAD: begin
                fu_s        = FU_S_LD_ST;
                s_reg_write = 1'b1;
                imm         = imm_i;
            end
            OP_STORE: begin
                fu_s = FU_S_LD_ST;
                imm  = imm_s;
            end
            OP_BRANCH: begin
                fu_s = FU_S_BRANCH;
                imm  = imm_b;
            end
            OP_JAL: begin
                fu_s = FU_S_BRANCH;
                jal  = 1'b1;
                imm  = imm_j;
            end
            OP_JALR: begin
                fu_s = FU_S_BRANCH;
                jalr = 1'b1;
                imm  = imm_i;
            end
            OP_MLOAD: begin
                fu_m        = FU_M_LD_ST;
                m_reg_write = 1'b1;
                imm         = imm_m;
            end
            OP_MSTORE: begin
                fu_m = FU_M_LD_ST;
                imm  = imm_m;
            end
            OP_GEMM: begin
                fu_m        = FU_M_GEMM;
                m_reg_write = 1'b1;
            end
            OP_HALT: begin
                halt = 1'b1;
            end
            // unknown opcodes fall through as nop
            default: begin
                op = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/reg_status_table.sv
`timescale 1ns/10ps
`default_nettype none

module reg_status_table #(
    parameter int REG_N = 32,
    parameter int TAG_W = 2
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     di_write,
    input  logic [$clog2(REG_N)-1:0] di_sel,
    input  logic [TAG_W-1:0]         di_tag,
    input  logic                     di_spec,
    input  logic                     wb_write,
    input  logic [$clog2(REG_N)-1:0] wb_sel,
    input  logic                     flush,
    input  logic                     resolved,
    input  logic [$clog2(REG_N)-1:0] rd_sel_a,
    input  logic [$clog2(REG_N)-1:0] rd_sel_b,
    input  logic [$clog2(REG_N)-1:0] rd_sel_c,
    output logic [TAG_W-1:0]         rd_tag_a,
    output logic [TAG_W-1:0]         rd_tag_b,
    output logic [TAG_W-1:0]         rd_tag_c,
    output logic                     busy_a
);

    localparam int IDX_W = $clog2(REG_N);

    logic [REG_N-1:0] pending;
    logic [REG_N-1:0] spec_bit;
    logic [TAG_W-1:0] tag [REG_N];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending  <= '0;
            spec_bit <= '0;
            for (int i = 0; i < REG_N; i++) begin
                tag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REG_N; i++) begin
                // a new reservation beats a release of the same register
                if (di_write && di_sel == IDX_W'(i)) begin
                    pending[i]  <= 1'b1;
                    tag[i]      <= di_tag;
                    spec_bit[i] <= di_spec;
                end else if ((flush && spec_bit[i]) || (wb_write && wb_sel == IDX_W'(i))) begin
                    pending[i]  <= 1'b0;
                    tag[i]      <= '0;
                    spec_bit[i] <= 1'b0;
                end else if (resolved) begin
                    spec_bit[i] <= 1'b0;
                end
            end
        end
    end

    // reads see a same-cycle writeback as ready
    always_comb begin
        rd_tag_a = (wb_write && wb_sel == rd_sel_a) ? '0 : tag[rd_sel_a];
        rd_tag_b = (wb_write && wb_sel == rd_sel_b) ? '0 : tag[rd_sel_b];
        rd_tag_c = (wb_write && wb_sel == rd_sel_c) ? '0 : tag[rd_sel_c];
        busy_a   = pending[rd_sel_a];
    end

endmodule

`default_nettype wire

//--- rtl/dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch (
    input  logic                     CLK,
    input  logic                     nRST,
    // fetch
    input  dispatch_pkg::word_t      imemload,
    input  dispatch_pkg::word_t      fetch_br_pc,
    input  logic                     fetch_br_pred,
    output logic                     freeze,
    output logic                     jump,
    // execute and writeback
    input  dispatch_pkg::fu_mask_t   fu_busy,
    input  logic                     branch_miss,
    input  logic                     branch_resolved,
    input  logic                     wb_s_en,
    input  dispatch_pkg::sreg_t      wb_s_sel,
    input  logic                     wb_m_en,
    input  dispatch_pkg::mreg_t      wb_m_sel,
    // issue to status tables
    output logic                     issue_s_en,
    output logic                     issue_m_en,
    output logic                     issue_g_en,
    output dispatch_pkg::fu_s_t      issue_fu_s,
    output dispatch_pkg::sreg_t      issue_rd,
    output dispatch_pkg::sreg_t      issue_rs1,
    output dispatch_pkg::sreg_t      issue_rs2,
    output dispatch_pkg::imm_t       issue_imm,
    output dispatch_pkg::op_t        issue_op,
    output logic                     issue_spec,
    output dispatch_pkg::tag_t       issue_t1,
    output dispatch_pkg::tag_t       issue_t2,
    output dispatch_pkg::mreg_t      issue_md,
    output dispatch_pkg::tag_t       issue_mt,
    output dispatch_pkg::tag_t       issue_gt1,
    output dispatch_pkg::tag_t       issue_gt2,
    output dispatch_pkg::tag_t       issue_gt3,
    // registered stage toward execute
    output dispatch_pkg::fu_s_t      out_fu_s,
    output dispatch_pkg::fu_m_t      out_fu_m,
    output logic                     out_halt,
    output logic                     out_spec,
    output dispatch_pkg::word_t      out_br_pc,
    output logic                     out_br_pred
);

    import dispatch_pkg::*;

    fu_s_t fu_s;
    fu_m_t fu_m;
    logic  s_reg_write;
    logic  m_reg_write;
    logic  jal;
    logic  jalr;
    logic  halt;
    logic  lui;
    imm_t  imm;
    op_t   op;

    sreg_t s_rd;
    sreg_t s_rs1;
    sreg_t s_rs2;
    mreg_t m_rd;
    mreg_t m_rs1;
    mreg_t m_rs2;

    logic  s_writes;
    logic  struct_haz;
    logic  waw;
    logic  hazard;
    logic  go;

    logic  s_di_write;
    tag_t  s_di_tag;
    logic  m_di_write;
    tag_t  m_di_tag;
    logic  s_busy_rd;
    tag_t  m_tag_md;
    logic  m_busy_md;

    logic  spec;
    logic  n_spec;
    logic  jump_q;
    logic  n_jump;
    word_t n_br_pc;
    logic  n_br_pred;

    control_unit cu0 (
        .instr       (imemload),
        .fu_s        (fu_s),
        .fu_m        (fu_m),
        .s_reg_write (s_reg_write),
        .m_reg_write (m_reg_write),
        .jal         (jal),
        .jalr        (jalr),
        .halt        (halt),
        .lui         (lui),
        .imm         (imm),
        .op          (op)
    );

    // register fields, matrix ld/st moves the scalar base up
    assign s_rd  = imemload[11:7];
    assign s_rs1 = (fu_m == FU_M_LD_ST) ? imemload[25:21] : imemload[19:15];
    assign s_rs2 = imemload[24:20];
    assign m_rd  = imemload[31:26];
    assign m_rs1 = imemload[25:20];
    assign m_rs2 = imemload[19:14];

    assign s_writes = s_reg_write | jal | jalr;

    always_comb begin
        case (fu_s)
            FU_S_ALU:    struct_haz = fu_busy[FU_ALU_BIT];
            FU_S_LD_ST:  struct_haz = fu_busy[FU_LD_ST_BIT];
            FU_S_BRANCH: struct_haz = fu_busy[FU_BRANCH_BIT];
            default: begin
                case (fu_m)
                    FU_M_LD_ST: struct_haz = fu_busy[FU_MLS_BIT];
                    FU_M_GEMM:  struct_haz = fu_busy[FU_GEMM_BIT];
                    default:    struct_haz = 1'b0;
                endcase
            end
        endcase
    end

    assign waw    = m_reg_write ? m_busy_md : (s_writes & s_busy_rd);
    assign hazard = struct_haz | waw;
    assign freeze = hazard;
    assign go     = ~hazard & ~branch_miss;

    assign issue_s_en = go & (fu_s != FU_S_NONE);
    assign issue_m_en = go & (fu_m == FU_M_LD_ST);
    assign issue_g_en = go & (fu_m == FU_M_GEMM);

    // lui carries no source registers
    assign issue_fu_s = fu_s;
    assign issue_rd   = s_rd;
    assign issue_rs1  = lui ? '0 : s_rs1;
    assign issue_rs2  = s_rs2;
    assign issue_imm  = imm;
    assign issue_op   = op;
    assign issue_spec = spec & ~(branch_resolved | branch_miss);
    assign issue_md   = m_rd;
    assign issue_mt   = m_tag_md;
    // gemm accumulates into md, so its third operand is the md tag
    assign issue_gt3  = m_tag_md;

    // destination reservations
    assign s_di_write = go & s_writes;
    assign s_di_tag   = (fu_s == FU_S_LD_ST) ? TAG_S_LOAD :
                        (jal | jalr)         ? TAG_S_JUMP : TAG_S_ALU;
    assign m_di_write = go & m_reg_write;
    assign m_di_tag   = (fu_m == FU_M_GEMM) ? TAG_M_GEMM : TAG_M_LOAD;

    // port a only serves the waw check on rd
    reg_status_table #(.REG_N(SREG_N), .TAG_W(2)) rsts0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (s_di_write),
        .di_sel   (s_rd),
        .di_tag   (s_di_tag),
        .di_spec  (issue_spec),
        .wb_write (wb_s_en),
        .wb_sel   (wb_s_sel),
        .flush    (branch_miss),
        .resolved (branch_resolved),
        .rd_sel_a (s_rd),
        .rd_sel_b (issue_rs1),
        .rd_sel_c (s_rs2),
        .rd_tag_a (),
        .rd_tag_b (issue_t1),
        .rd_tag_c (issue_t2),
        .busy_a   (s_busy_rd)
    );

    // matrix entries are never speculative
    reg_status_table #(.REG_N(MREG_N), .TAG_W(2)) rstm0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (m_di_write),
        .di_sel   (m_rd),
        .di_tag   (m_di_tag),
        .di_spec  (1'b0),
        .wb_write (wb_m_en),
        .wb_sel   (wb_m_sel),
        .flush    (1'b0),
        .resolved (1'b0),
        .rd_sel_a (m_rd),
        .rd_sel_b (m_rs1),
        .rd_sel_c (m_rs2),
        .rd_tag_a (m_tag_md),
        .rd_tag_b (issue_gt1),
        .rd_tag_c (issue_gt2),
        .busy_a   (m_busy_md)
    );

    // speculation and jump state, set wins over clear
    always_comb begin
        n_spec = spec;
        if (fu_s == FU_S_BRANCH && !(jal || jalr)) begin
            n_spec = 1'b1;
        end else if (branch_resolved || branch_miss) begin
            n_spec = 1'b0;
        end
        n_jump = jump_q;
        if (jal || jalr) begin
            n_jump = 1'b1;
        end else if (branch_resolved || branch_miss) begin
            n_jump = 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec   <= 1'b0;
            jump_q <= 1'b0;
        end else begin
            spec   <= n_spec;
            jump_q <= n_jump;
        end
    end

    assign jump = (n_jump | jump_q) & ~fu_busy[FU_BRANCH_BIT];

    // prediction info only follows branch-unit instructions
    assign n_br_pc   = (fu_s == FU_S_BRANCH) ? fetch_br_pc : out_br_pc;
    assign n_br_pred = (fu_s == FU_S_BRANCH) ? fetch_br_pred : out_br_pred;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_fu_s    <= FU_S_NONE;
            out_fu_m    <= FU_M_NONE;
            out_halt    <= 1'b0;
            out_spec    <= 1'b0;
            out_br_pc   <= '0;
            out_br_pred <= 1'b0;
        end else if (branch_miss) begin
            out_fu_s    <= FU_S_NONE;
            out_fu_m    <= FU_M_NONE;
            out_halt    <= 1'b0;
            out_spec    <= 1'b0;
            out_br_pc   <= '0;
            out_br_pred <= 1'b0;
        end else if (!hazard) begin
            out_fu_s    <= fu_s;
            out_fu_m    <= fu_m;
            out_halt    <= halt;
            out_spec    <= spec;
            out_br_pc   <= n_br_pc;
            out_br_pred <= n_br_pred;
        end
    end

endmodule

`default_nettype wire

//--- testbench/dispatch_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_checker (
    input logic CLK,
    input logic nRST,
    input logic freeze,
    input logic branch_miss,
    input logic issue_s_en,
    input logic issue_m_en,
    input logic issue_g_en,
    input logic out_halt
);

    logic any_issue;

    assign any_issue = issue_s_en | issue_m_en | issue_g_en;

    // a stalled word never reaches a status table
    a_freeze_blocks: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |-> !any_issue)
        else $error("issue strobe high while freeze is set");

    a_miss_blocks: assert property (@(posedge CLK) disable iff (!nRST)
        branch_miss |-> !any_issue)
        else $error("issue strobe high during branch_miss");

    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({issue_s_en, issue_m_en, issue_g_en}))
        else $error("more than one issue strobe high");

    // flush zeroes the registered stage
    a_miss_clears_halt: assert property (@(posedge CLK) disable iff (!nRST)
        branch_miss |=> !out_halt)
        else $error("out_halt set in the cycle after branch_miss");

endmodule

bind dispatch dispatch_checker chk0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .freeze      (freeze),
    .branch_miss (branch_miss),
    .issue_s_en  (issue_s_en),
    .issue_m_en  (issue_m_en),
    .issue_g_en  (issue_g_en),
    .out_halt    (out_halt)
);

`default_nettype wire

//--- testbench/tb_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dispatch;

    import dispatch_pkg::*;

    localparam int HALF_PERIOD = 20;
    localparam int MAX_LINES   = 200;
    localparam     TRACE_FILE  = "testbench/dispatch_trace.txt";

    logic     CLK;
    logic     nRST;
    word_t    imemload;
    word_t    fetch_br_pc;
    logic     fetch_br_pred;
    fu_mask_t fu_busy;
    logic     branch_miss;
    logic     branch_resolved;
    logic     wb_s_en;
    sreg_t    wb_s_sel;
    logic     wb_m_en;
    mreg_t    wb_m_sel;

    logic     freeze;
    logic     jump;
    logic     issue_s_en;
    logic     issue_m_en;
    logic     issue_g_en;
    fu_s_t    issue_fu_s;
    sreg_t    issue_rd;
    sreg_t    issue_rs1;
    sreg_t    issue_rs2;
    imm_t     issue_imm;
    op_t      issue_op;
    logic     issue_spec;
    tag_t     issue_t1;
    tag_t     issue_t2;
    mreg_t    issue_md;
    tag_t     issue_mt;
    tag_t     issue_gt1;
    tag_t     issue_gt2;
    tag_t     issue_gt3;
    fu_s_t    out_fu_s;
    fu_m_t    out_fu_m;
    logic     out_halt;
    logic     out_spec;
    word_t    out_br_pc;
    logic     out_br_pred;

    // one trace line, inputs then expected values
    word_t    t_imem;
    word_t    t_pc;
    logic     t_pred;
    fu_mask_t t_busy;
    logic     t_miss;
    logic     t_res;
    logic     t_wbs;
    int       t_wbs_sel;
    logic     t_wbm;
    int       t_wbm_sel;
    logic     e_freeze;
    logic     e_s;
    logic     e_m;
    logic     e_g;
    int       e_t1;
    int       e_t2;
    logic     e_spec;
    logic     e_jump;
    logic     e_halt;

    // combinational outputs captured before the rising edge
    logic     s_freeze;
    logic     s_s;
    logic     s_m;
    logic     s_g;
    tag_t     s_t1;
    tag_t     s_t2;
    logic     s_spec;
    logic     s_jump;

    // reference model of the registered stage
    logic     x_spec;
    logic     x_out_spec;
    fu_s_t    x_fu_s;
    fu_m_t    x_fu_m;
    word_t    x_br_pc;
    logic     x_br_pred;

    int       errors;
    int       checks;
    int       tests;
    int       test_errors;
    int       test_cycles;
    string    test_name;

    dispatch dut0 (.*);

    always #HALF_PERIOD CLK = ~CLK;

    // target units by opcode
    function automatic fu_s_t scalar_unit(input word_t w);
        case (w[6:0])
            OP_ALU_R, OP_ALU_I, OP_LUI:    return FU_S_ALU;
            OP_LOAD, OP_STORE:             return FU_S_LD_ST;
            OP_BRANCH, OP_JAL, OP_JALR:    return FU_S_BRANCH;
            default:                       return FU_S_NONE;
        endcase
    endfunction

    function automatic fu_m_t matrix_unit(input word_t w);
        case (w[6:0])
            OP_MLOAD, OP_MSTORE: return FU_M_LD_ST;
            OP_GEMM:             return FU_M_GEMM;
            default:             return FU_M_NONE;
        endcase
    endfunction

    function automatic sreg_t source_base(input word_t w);
        if (w[6:0] == OP_MLOAD || w[6:0] == OP_MSTORE) begin
            return w[25:21];
        end
        return w[19:15];
    endfunction

    task automatic compare_value(input string signal, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch in %0s: %0s expected %0h, actual %0h",
                     test_name, signal, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            $display("Test %0s finished: %0d cycles, %0d errors",
                     test_name, test_cycles, test_errors);
            tests++;
        end
        test_errors = 0;
        test_cycles = 0;
    endtask

    task automatic start_test(input string name);
        if (name != test_name) begin
            finish_test();
            test_name = name;
        end
    endtask

    task automatic run_cycle();
        @(negedge CLK);
        imemload        = t_imem;
        fetch_br_pc     = t_pc;
        fetch_br_pred   = t_pred;
        fu_busy         = t_busy;
        branch_miss     = t_miss;
        branch_resolved = t_res;
        wb_s_en         = t_wbs;
        wb_s_sel        = sreg_t'(t_wbs_sel);
        wb_m_en         = t_wbm;
        wb_m_sel        = mreg_t'(t_wbm_sel);
        #(HALF_PERIOD - 5);
        s_freeze = freeze;
        s_s      = issue_s_en;
        s_m      = issue_m_en;
        s_g      = issue_g_en;
        s_t1     = issue_t1;
        s_t2     = issue_t2;
        s_spec   = issue_spec;
        s_jump   = jump;
        compare_value("issue_rd", t_imem[11:7], issue_rd);
        compare_value("issue_rs2", t_imem[24:20], issue_rs2);
        compare_value("issue_md", t_imem[31:26], issue_md);
        compare_value("issue_fu_s", scalar_unit(t_imem), issue_fu_s);
        if (t_imem[6:0] != OP_LUI) begin
            compare_value("issue_rs1", source_base(t_imem), issue_rs1);
        end
        // next state of the registered stage
        if (t_miss) begin
            x_fu_s     = FU_S_NONE;
            x_fu_m     = FU_M_NONE;
            x_out_spec = 1'b0;
            x_br_pc    = '0;
            x_br_pred  = 1'b0;
        end else if (!e_freeze) begin
            x_fu_s     = scalar_unit(t_imem);
            x_fu_m     = matrix_unit(t_imem);
            x_out_spec = x_spec;
            if (scalar_unit(t_imem) == FU_S_BRANCH) begin
                x_br_pc   = t_pc;
                x_br_pred = t_pred;
            end
        end
        if (t_imem[6:0] == OP_BRANCH) begin
            x_spec = 1'b1;
        end else if (t_res || t_miss) begin
            x_spec = 1'b0;
        end
        // registered outputs are read after the edge
        #(HALF_PERIOD);
        compare_value("freeze", e_freeze, s_freeze);
        compare_value("issue_s_en", e_s, s_s);
        compare_value("issue_m_en", e_m, s_m);
        compare_value("issue_g_en", e_g, s_g);
        compare_value("issue_t1", e_t1, s_t1);
        compare_value("issue_t2", e_t2, s_t2);
        compare_value("issue_spec", e_spec, s_spec);
        compare_value("jump", e_jump, s_jump);
        compare_value("out_halt", e_halt, out_halt);
        compare_value("out_fu_s", x_fu_s, out_fu_s);
        compare_value("out_fu_m", x_fu_m, out_fu_m);
        compare_value("out_spec", x_out_spec, out_spec);
        compare_value("out_br_pc", x_br_pc, out_br_pc);
        compare_value("out_br_pred", x_br_pred, out_br_pred);
        test_cycles++;
    endtask

    initial begin
        int               fd;
        int               n;
        int               lines;
        logic             end_seen;
        logic [8*160-1:0] line_buf;
        logic [8*32-1:0]  tok;
        logic [8*32-1:0]  name;
        CLK             = 1'b0;
        nRST            = 1'b0;
        imemload        = '0;
        fetch_br_pc     = '0;
        fetch_br_pred   = 1'b0;
        fu_busy         = '0;
        branch_miss     = 1'b0;
        branch_resolved = 1'b0;
        wb_s_en         = 1'b0;
        wb_s_sel        = '0;
        wb_m_en         = 1'b0;
        wb_m_sel        = '0;
        x_spec          = 1'b0;
        x_out_spec      = 1'b0;
        x_fu_s          = FU_S_NONE;
        x_fu_m          = FU_M_NONE;
        x_br_pc         = '0;
        x_br_pred       = 1'b0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        test_errors     = 0;
        test_cycles     = 0;
        test_name       = "";
        lines           = 0;
        end_seen        = 1'b0;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %0s", TRACE_FILE);
            errors++;
        end

        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        // registered stage and state come out of reset cleared
        start_test("reset_state");
        compare_value("out_fu_s", FU_S_NONE, out_fu_s);
        compare_value("out_fu_m", FU_M_NONE, out_fu_m);
        compare_value("out_halt", 0, out_halt);
        compare_value("out_spec", 0, out_spec);
        compare_value("out_br_pc", 0, out_br_pc);
        compare_value("out_br_pred", 0, out_br_pred);
        compare_value("jump", 0, jump);

        if (fd != 0) begin
            while (!end_seen && lines < MAX_LINES && !$feof(fd)) begin
                line_buf = '0;
                tok      = '0;
                n        = $fgets(line_buf, fd);
                lines++;
                if (n > 0 && $sscanf(line_buf, "%s", tok) == 1 && tok != "#") begin
                    if (tok == "end") begin
                        end_seen = 1'b1;
                    end else begin
                        n = $sscanf(line_buf,
                            "%s %h %h %b %h %b %b %b %d %b %d %b %b %b %b %d %d %b %b %b",
                            name, t_imem, t_pc, t_pred, t_busy, t_miss, t_res,
                            t_wbs, t_wbs_sel, t_wbm, t_wbm_sel, e_freeze, e_s, e_m,
                            e_g, e_t1, e_t2, e_spec, e_jump, e_halt);
                        if (n != 20) begin
                            $display("Trace line %0d could not be parsed", lines);
                            errors++;
                        end else begin
                            start_test($sformatf("%0s", name));
                            run_cycle();
                        end
                    end
                end
            end
            if (!end_seen) begin
                if (lines >= MAX_LINES) begin
                    $display("Timeout: no end marker within %0d trace lines", MAX_LINES);
                end else begin
                    $display("The trace ended before its end marker");
                end
                errors++;
            end
            $fclose(fd);
        end

        finish_test();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/dispatch_trace.txt
# in:  name imemload fetch_br_pc br_pred fu_busy miss resolved wb_s_en wb_s_sel wb_m_en wb_m_sel
# exp: freeze issue_s_en issue_m_en issue_g_en t1 t2 issue_spec jump out_halt
reset_nop    00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
reset_nop    00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
reset_nop    00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
raw_alu      002082b3 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
raw_alu      00328333 00000000 0 00 0 0 0 0  0 0   0 1 0 0 1 0 0 0 0
raw_alu      005083b3 00000000 0 00 0 0 1 5  0 0   0 1 0 0 0 0 0 0 0
raw_alu      00628433 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 1 0 0 0
waw_scalar   00328333 00000000 0 00 0 0 0 0  0 0   1 0 0 0 0 0 0 0 0
waw_scalar   00328333 00000000 0 00 0 0 1 6  0 0   1 0 0 0 0 0 0 0 0
waw_scalar   00328333 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
stall_gemm   10108077 00000000 0 10 0 0 0 0  0 0   1 0 0 0 0 0 0 0 0
stall_gemm   10108077 00000000 0 10 0 0 0 0  0 0   1 0 0 0 0 0 0 0 0
stall_gemm   10108077 00000000 0 00 0 0 0 0  0 0   0 0 0 1 0 0 0 0 0
waw_matrix   10108077 00000000 0 00 0 0 0 0  0 0   1 0 0 0 0 0 0 0 0
waw_matrix   10108077 00000000 0 00 0 0 0 0  1 4   1 0 0 0 0 0 0 0 0
waw_matrix   10108077 00000000 0 00 0 0 0 0  0 0   0 0 0 1 0 0 0 0 0
waw_matrix   24200007 00000000 0 00 0 0 0 0  0 0   0 0 1 0 0 0 0 0 0
spec_miss    00208063 00000100 1 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
spec_miss    00208533 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 1 0 0
spec_miss    00008583 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 1 0 0
spec_miss    00b50633 00000000 0 00 1 0 0 0  0 0   0 0 0 0 1 3 0 0 0
spec_miss    00208533 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
spec_miss    00008583 00000000 0 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
spec_resolve 00208063 00000200 0 00 0 0 0 0  0 0   0 1 0 0 0 0 0 0 0
spec_resolve 00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 1 0 0
spec_resolve 00000000 00000000 0 00 0 1 0 0  0 0   0 0 0 0 0 0 0 0 0
spec_resolve 00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
jump_jal     000006ef 00000300 1 00 0 0 0 0  0 0   0 1 0 0 0 0 0 1 0
jump_jal     00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 1 0
jump_jal     00000000 00000000 0 04 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
jump_jal     00000000 00000000 0 00 0 1 0 0  0 0   0 0 0 0 0 0 0 1 0
jump_jal     00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
halt         0000007f 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 1
halt         00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
halt_miss    0000007f 00000000 0 00 1 0 0 0  0 0   0 0 0 0 0 0 0 0 0
halt_miss    00000000 00000000 0 00 0 0 0 0  0 0   0 0 0 0 0 0 0 0 0
end

//--- tb.f
rtl/dispatch_pkg.sv
rtl/control_unit.sv
rtl/reg_status_table.sv
rtl/dispatch.sv
testbench/dispatch_checker.sv
testbench/tb_dispatch.sv
